/* dwc_upsizer.sv */
// Write data width upsizer
`timescale 1ns/1ps

module dwc_upsizer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     narrow_valid,
  input  upsize_pkg::narrow_beat_t narrow_beat,
  output logic                     wide_valid,
  output upsize_pkg::wide_beat_t   wide_beat,
  output logic [15:0]              beat_count
);

  // Steering outputs
  upsize_pkg::lane_write_t             lane_write;
  logic [upsize_pkg::narrow_width-1:0] lane_data;
  logic [upsize_pkg::narrow_strb-1:0]  lane_strb;
  logic                                close;
  logic                                close_last;

  // Lane contents toward the packer
  logic [upsize_pkg::lane_count-1:0][upsize_pkg::narrow_width-1:0] lane_words;
  logic [upsize_pkg::lane_count-1:0][upsize_pkg::narrow_strb-1:0]  lane_byte_en;
  // Clear from the packer back to every lane
  logic                                lane_clear;

  // Input stage
  lane_steering i_lane_steering (
    .clk          (clk),
    .reset        (reset),
    .narrow_valid (narrow_valid),
    .narrow_beat  (narrow_beat),
    .lane_write   (lane_write),
    .lane_data    (lane_data),
    .lane_strb    (lane_strb),
    .close        (close),
    .close_last   (close_last)
  );

  // One merge register per lane
  for (genvar i = 0; i < upsize_pkg::lane_count; i++) begin : g_lane
    narrow_lane i_narrow_lane (
      .clk          (clk),
      .reset        (reset),
      .write        (lane_write[i]),
      .clear        (lane_clear),
      .data         (lane_data),
      .strb         (lane_strb),
      .lane_word    (lane_words[i]),
      .lane_byte_en (lane_byte_en[i])
    );
  end

  // Output stage
  wide_beat_packer i_wide_beat_packer (
    .clk          (clk),
    .reset        (reset),
    .close        (close),
    .close_last   (close_last),
    .lane_words   (lane_words),
    .lane_byte_en (lane_byte_en),
    .lane_clear   (lane_clear),
    .wide_valid   (wide_valid),
    .wide_beat    (wide_beat),
    .beat_count   (beat_count)
  );

endmodule

/* dwc_upsizer_assertions.sv */
// Upsizer protocol assertions
`timescale 1ns/1ps

module dwc_upsizer_assertions (
  input logic                     clk,
  input logic                     reset,
  input logic                     narrow_valid,
  input upsize_pkg::narrow_beat_t narrow_beat,
  input upsize_pkg::lane_write_t  lane_write,
  input logic                     close,
  input logic                     wide_valid
);

  // Open wide beat and the lane of its latest narrow beat
  logic                             open_q;
  logic [upsize_pkg::lane_bits-1:0] prev_lane_q;
  logic                             beat_closes;

  // Narrow beat that ends a wide beat, lane 7 or last
  assign beat_closes = narrow_beat.last ||
      (narrow_beat.lane == upsize_pkg::lane_bits'(upsize_pkg::lane_count - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      open_q      <= 1'b0;
      prev_lane_q <= '0;
    end else if (narrow_valid) begin
      open_q      <= !beat_closes;
      prev_lane_q <= narrow_beat.lane;
    end
  end

  // Close rises one cycle after a closing narrow beat and at no other time
  close_follows_beat: assert property (@(posedge clk) disable iff (reset)
    close == $past(narrow_valid && !reset && beat_closes))
    else $error("close does not match the narrow beat one cycle earlier");

  // Wide beat comes exactly one cycle after close
  // Two cycles after the closing narrow beat
  valid_follows_close: assert property (@(posedge clk) disable iff (reset)
    wide_valid == ($past(narrow_valid && !reset && beat_closes, 2) && !$past(reset)))
    else $error("wide_valid not exactly one cycle after close");

  // Only the lane of the previous narrow beat is written
  write_decode: assert property (@(posedge clk) disable iff (reset)
    lane_write == ($past(narrow_valid && !reset) ?
                   (upsize_pkg::lane_write_t'(1) << $past(narrow_beat.lane)) : '0))
    else $error("lane_write is not the one-hot lane of the previous narrow beat");

  // Repeats of a lane are allowed for byte merging
  lanes_rise: assert property (@(posedge clk) disable iff (reset)
    (narrow_valid && open_q) |-> (narrow_beat.lane >= prev_lane_q))
    else $error("lane offset fell inside an open wide beat");

endmodule

bind dwc_upsizer dwc_upsizer_assertions i_dwc_upsizer_assertions (
  .clk          (clk),
  .reset        (reset),
  .narrow_valid (narrow_valid),
  .narrow_beat  (narrow_beat),
  .lane_write   (lane_write),
  .close        (close),
  .wide_valid   (wide_valid)
);

/* lane_steering.sv */
// Narrow beat steering stage
`timescale 1ns/1ps

module lane_steering (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           narrow_valid,
  input  upsize_pkg::narrow_beat_t       narrow_beat,
  output upsize_pkg::lane_write_t        lane_write,
  output logic [upsize_pkg::narrow_width-1:0] lane_data,
  output logic [upsize_pkg::narrow_strb-1:0]  lane_strb,
  output logic                           close,
  output logic                           close_last
);

  // Registered copy of the incoming beat
  logic                     valid_q;
  upsize_pkg::narrow_beat_t beat_q;

  // Input valid delayed by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= narrow_valid;
    end
  end

  // Payload is only captured when a beat arrives
  always_ff @(posedge clk) begin
    if (narrow_valid) begin
      beat_q <= narrow_beat;
    end
  end

  // One-hot decode of the lane offset
  always_comb begin
    lane_write = '0;
    if (valid_q) begin
      lane_write[beat_q.lane] = 1'b1;
    end
  end

  // Data and strobes go to every lane
  // Only the lane with its write bit set picks them up
  assign lane_data = beat_q.data;
  assign lane_strb = beat_q.strb;

  // Close rule for the whole design
  // Top lane filled or source marked the end of a burst
  assign close = valid_q &&
                 ((beat_q.lane == upsize_pkg::lane_bits'(upsize_pkg::lane_count - 1)) ||
                  beat_q.last);

  // Last flag travels with the closing beat
  assign close_last = valid_q && beat_q.last;

endmodule

/* narrow_lane.sv */
// Single lane merge register
`timescale 1ns/1ps

module narrow_lane (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                write,
  input  logic                                clear,
  input  logic [upsize_pkg::narrow_width-1:0] data,
  input  logic [upsize_pkg::narrow_strb-1:0]  strb,
  output logic [upsize_pkg::narrow_width-1:0] lane_word,
  output logic [upsize_pkg::narrow_strb-1:0]  lane_byte_en
);

  // Merged word and its accumulated byte enables
  logic [upsize_pkg::narrow_width-1:0] word_q;
  logic [upsize_pkg::narrow_strb-1:0]  byte_en_q;

  // Byte-wise merge
  // Clear drops old contents first and a coincident write lands on top
  always_ff @(posedge clk) begin
    if (reset) begin
      word_q    <= '0;
      byte_en_q <= '0;
    end else begin
      for (int b = 0; b < upsize_pkg::narrow_strb; b++) begin
        if (write && strb[b]) begin
          // Later write wins on the bytes it strobes
          word_q[b*8 +: 8] <= data[b*8 +: 8];
          byte_en_q[b]     <= 1'b1;
        end else if (clear) begin
          // Unwritten bytes of the next beat read as zero
          word_q[b*8 +: 8] <= 8'h00;
          byte_en_q[b]     <= 1'b0;
        end
      end
    end
  end

  // Lane contents are always visible to the packer
  assign lane_word    = word_q;
  assign lane_byte_en = byte_en_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the width upsizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_dwc_upsizer -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_dwc_upsizer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "test passed"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi

/* tb_dwc_upsizer.sv */
// Width upsizer testbench
`timescale 1ns/1ps

module tb_dwc_upsizer;

  localparam int max_tests = 16;

  // DUT ports
  logic                     clk;
  logic                     reset;
  logic                     narrow_valid;
  upsize_pkg::narrow_beat_t narrow_beat;
  logic                     wide_valid;
  upsize_pkg::wide_beat_t   wide_beat;
  logic [15:0]              beat_count;

  // Beats to send and wide beats still expected, each tagged with its test
  upsize_pkg::narrow_beat_t in_beats[$];
  int                       in_test[$];
  upsize_pkg::wide_beat_t   exp_beats[$];
  int                       exp_test[$];

  // Per-test bookkeeping
  bit          test_no_gap[max_tests];
  int          test_left[max_tests];
  int          test_errors[max_tests];
  int          num_tests;
  int          total_expected;
  int          errors;
  int          failed_tests;
  bit          loaded;
  logic [31:0] lfsr_state;

  dwc_upsizer i_dwc_upsizer (
    .clk          (clk),
    .reset        (reset),
    .narrow_valid (narrow_valid),
    .narrow_beat  (narrow_beat),
    .wide_valid   (wide_valid),
    .wide_beat    (wide_beat),
    .beat_count   (beat_count)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Parse the case file into tests, narrow beats and expected wide beats
  task automatic load_cases();
    int                       fd;
    int                       n;
    int                       lane;
    int                       strb;
    int                       last;
    int                       no_gap;
    logic [31:0]              data;
    logic [255:0]             wdata;
    logic [31:0]              wstrb;
    string                    line;
    upsize_pkg::narrow_beat_t nb;
    upsize_pkg::wide_beat_t   wb;
    fd = $fopen("upsize_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open upsize_cases.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0) begin
          // First character tells the line kind, comments fall through
          case (line.getc(0))
            "t": begin
              n = $sscanf(line, "t %d", no_gap);
              test_no_gap[num_tests] = (no_gap != 0);
              num_tests++;
            end
            "i": begin
              n = $sscanf(line, "i %h %h %h %h", lane, data, strb, last);
              if (n != 4) begin
                $display("malformed narrow beat line in case file");
                errors++;
              end
              nb.lane = lane[2:0];
              nb.data = data;
              nb.strb = strb[3:0];
              nb.last = last[0];
              in_beats.push_back(nb);
              in_test.push_back(num_tests - 1);
            end
            "e": begin
              n = $sscanf(line, "e %h %h %h", wdata, wstrb, last);
              if (n != 3) begin
                $display("malformed wide beat line in case file");
                errors++;
              end
              wb.data.flat = wdata;
              wb.strb      = wstrb;
              wb.last      = last[0];
              exp_beats.push_back(wb);
              exp_test.push_back(num_tests - 1);
              test_left[num_tests - 1]++;
              total_expected++;
            end
            default: begin
            end
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // Send every narrow beat, with 0 to 3 idle cycles unless the test is gapless
  task automatic drive_beats();
    int gap;
    for (int i = 0; i < in_beats.size(); i++) begin
      @(posedge clk);
      narrow_valid <= 1'b1;
      narrow_beat  <= in_beats[i];
      gap = 0;
      if (!test_no_gap[in_test[i]]) begin
        // One LFSR step per random bit
        lfsr_state = lfsr_next(lfsr_state);
        gap[0]     = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap[1]     = lfsr_state[0];
      end
      repeat (gap) begin
        @(posedge clk);
        narrow_valid <= 1'b0;
      end
    end
    @(posedge clk);
    narrow_valid <= 1'b0;
  endtask

  // One line per test once its last wide beat is checked
  function automatic void report_test(int t);
    if (test_errors[t] == 0) begin
      $display("test %0d: ok", t + 1);
    end else begin
      $display("test %0d: %0d mismatches", t + 1, test_errors[t]);
      failed_tests++;
    end
  endfunction

  // Compare one emitted wide beat with the next expected one
  task automatic check_wide_beat();
    upsize_pkg::wide_beat_t expected;
    int                     t;
    if (exp_beats.size() == 0) begin
      $display("wide_valid seen with no wide beat left to expect");
      errors++;
    end else begin
      expected = exp_beats.pop_front();
      t        = exp_test.pop_front();
      assert (wide_beat.data.flat === expected.data.flat) else begin
        $display("[FAIL] test %0d wide_beat.data got %h expected %h",
                 t + 1, wide_beat.data.flat, expected.data.flat);
        test_errors[t]++;
        errors++;
      end
      assert (wide_beat.strb === expected.strb) else begin
        $display("[FAIL] test %0d wide_beat.strb got %h expected %h",
                 t + 1, wide_beat.strb, expected.strb);
        test_errors[t]++;
        errors++;
      end
      assert (wide_beat.last === expected.last) else begin
        $display("[FAIL] test %0d wide_beat.last got %h expected %h",
                 t + 1, wide_beat.last, expected.last);
        test_errors[t]++;
        errors++;
      end
      test_left[t]--;
      if (test_left[t] == 0) begin
        report_test(t);
      end
    end
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!reset && wide_valid) begin
      check_wide_beat();
    end
  end

  // Watchdog sized from the number of case lines
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = (in_beats.size() + exp_beats.size()) * 8 * 20 + 1000;
    #(limit_ns);
    $display("run timed out after %0d ns with %0d wide beats never seen",
             limit_ns, exp_beats.size());
    $display("test failed");
    $finish;
  end

  initial begin
    reset          = 1'b1;
    narrow_valid   = 1'b0;
    narrow_beat    = '0;
    lfsr_state     = 32'h4e8d;
    num_tests      = 0;
    total_expected = 0;
    errors         = 0;
    failed_tests   = 0;
    load_cases();
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    drive_beats();
    while (exp_beats.size() != 0) begin
      @(posedge clk);
    end
    // A few spare cycles to catch a stray wide_valid
    repeat (4) @(posedge clk);
    assert (beat_count == 16'(total_expected)) else begin
      $display("[FAIL] beat_count got %h expected %h", beat_count, 16'(total_expected));
      errors++;
    end
    $display("%0d tests, %0d with mismatches, %0d errors in total",
             num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* upsize_cases.txt */
# t <no_gap> <name> opens a test, i <lane> <data> <strb> <last> is a narrow beat
# e <wide data> <wide strb> <last> is the expected wide beat, all values in hex
t 0 full_packing
i 0 03020100 f 0
i 1 07060504 f 0
i 2 0b0a0908 f 0
i 3 0f0e0d0c f 0
i 4 13121110 f 0
i 5 17161514 f 0
i 6 1b1a1918 f 0
i 7 1f1e1d1c f 0
e 1f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100 ffffffff 0
t 0 early_close_on_last
i 0 deadbeef f 0
i 1 cafef00d 3 0
i 2 12345678 c 0
i 3 a5a5a5a5 f 1
e 00000000000000000000000000000000a5a5a5a5123400000000f00ddeadbeef 0000fc3f 1
t 0 byte_merging
i 0 11223344 3 0
i 0 aabbccdd c 0
i 1 55667788 f 0
i 1 99999999 6 0
i 2 01020304 1 1
e 00000000000000000000000000000000000000000000000455999988aabb3344 000001ff 1
t 1 back_to_back
i 5 55555555 f 0
i 6 66666666 f 0
i 7 77777777 f 0
i 0 0a0a0a0a 1 0
i 1 0b0b0b0b f 1
i 7 ffffffff f 1
i 0 c3c3c3c3 8 1
e 7777777766666666555555550000000000000000000000000000000000000000 fff00000 0
e 0000000000000000000000000000000000000000000000000b0b0b0b0000000a 000000f1 1
e ffffffff00000000000000000000000000000000000000000000000000000000 f0000000 1
e 00000000000000000000000000000000000000000000000000000000c3000000 00000008 1
t 0 sparse_lanes
i 2 44332211 5 0
i 4 88776655 a 0
i 7 0badf00d f 1
e 0badf00d00000000000000008800660000000000003300110000000000000000 f00a0500 1

/* upsize_pkg.sv */
// Width upsizer shared types
package upsize_pkg;

  // Number of narrow lanes packed into one wide beat
  localparam int lane_count = 8;
  // Width of the lane offset carried by each narrow beat
  localparam int lane_bits = 3;
  // Narrow data word width in bits
  localparam int narrow_width = 32;

  // Byte strobes per narrow word
  localparam int narrow_strb = narrow_width / 8;
  // Derived wide beat widths
  localparam int wide_width = lane_count * narrow_width;
  localparam int wide_strb = lane_count * narrow_strb;

  // One write strobe per lane
  typedef logic [lane_count-1:0] lane_write_t;

  // Narrow input beat as sent by the source
  typedef struct packed {
    logic [lane_bits-1:0]    lane;
    logic [narrow_width-1:0] data;
    logic [narrow_strb-1:0]  strb;
    logic                    last;
  } narrow_beat_t;

  // Wide data word seen either flat or split into lanes
  // Lane 0 sits in the low bits of the flat view
  typedef union packed {
    logic [wide_width-1:0]                   flat;
    logic [lane_count-1:0][narrow_width-1:0] lanes;
  } wide_data_u;

  // Wide output beat
  typedef struct packed {
    wide_data_u           data;
    logic [wide_strb-1:0] strb;
    logic                 last;
  } wide_beat_t;

endpackage

/* verilog.f */
upsize_pkg.sv
lane_steering.sv
narrow_lane.sv
wide_beat_packer.sv
dwc_upsizer.sv
dwc_upsizer_assertions.sv
tb_dwc_upsizer.sv

/* wide_beat_packer.sv */
// Wide beat assembly and output
`timescale 1ns/1ps

module wide_beat_packer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   close,
  input  logic                   close_last,
  input  logic [upsize_pkg::lane_count-1:0][upsize_pkg::narrow_width-1:0] lane_words,
  input  logic [upsize_pkg::lane_count-1:0][upsize_pkg::narrow_strb-1:0]  lane_byte_en,
  output logic                   lane_clear,
  output logic                   wide_valid,
  output upsize_pkg::wide_beat_t wide_beat,
  output logic [15:0]            beat_count
);

  // Close delayed by one cycle so the lanes hold the closing write
  logic close_q;
  logic last_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      close_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      close_q <= close;
      last_q  <= close_last;
    end
  end

  // Present the beat and empty the lanes in the same cycle
  assign wide_valid = close_q;
  assign lane_clear = close_q;

  // Place each lane into its slot of the wide word
  always_comb begin
    for (int i = 0; i < upsize_pkg::lane_count; i++) begin
      wide_beat.data.lanes[i] = lane_words[i];
      // Four strobe bits per lane in lane order
      wide_beat.strb[i*upsize_pkg::narrow_strb +: upsize_pkg::narrow_strb] = lane_byte_en[i];
    end
    wide_beat.last = last_q;
  end

  // Count of wide beats handed to the sink
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_count <= 16'd0;
    end else if (close_q) begin
      beat_count <= beat_count + 16'd1;
    end
  end

endmodule
